/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // data and address words
  typedef logic [31:0] word_t;

  // architectural register index
  typedef logic [4:0] reg_idx_t;

  // major opcode field, inst[6:0]
  typedef logic [6:0] opcode_t;

  localparam opcode_t OP_R      = 7'b0110011;
  localparam opcode_t OP_I      = 7'b0010011;
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B
  } alu_op_e;

  // writeback source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC_PLUS4
  } result_src_e;

  // next pc choice, decided in execute
  typedef enum logic [1:0] {
    PC_PLUS4,
    PC_BRANCH,
    PC_JALR
  } pc_src_e;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_src_e;

  // execute operand forwarding
  typedef enum logic [1:0] {
    FWD_REG,
    FWD_FROM_MEM,
    FWD_FROM_WB
  } fwd_sel_e;

endpackage

`default_nettype wire

/* logic/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  reg_idx_t ra1,
  input  reg_idx_t ra2,
  input  reg_idx_t wa,
  input  logic     we,
  input  word_t    wd,
  output word_t    rd1,
  output word_t    rd2
);

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  // write-before-read lets decode see the value written back this cycle
  assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

  // a write to x0 leaves every register as it was
  property p_x0_zero;
    @(posedge clk) (we && wa == '0) |=>
      (ra1 != $past(ra1) || (we && wa == ra1) || rd1 === $past(rd1)) &&
      (ra2 != $past(ra2) || (we && wa == ra2) || rd2 === $past(rd2));
  endproperty
  a_x0_zero: assert property (p_x0_zero) else $error("write to x0 changed a register read");

endmodule

`default_nettype wire

/* logic/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  output word_t   y,
  output logic    zero,
  output logic    neg,
  output logic    neg_unsigned
);

  // extra bit keeps the borrow of a - b
  logic [32:0] diff;
  logic        lt_signed;

  assign diff = {1'b0, a} - {1'b0, b};

  // signed less-than, overflow corrected when the signs differ
  assign lt_signed = (a[31] ^ b[31]) ? a[31] : diff[31];

  // flags for branch resolution
  assign zero         = (diff[31:0] == '0);
  assign neg          = lt_signed;
  assign neg_unsigned = diff[32];

  always_comb begin
    unique case (op)
      ALU_ADD:    y = a + b;
      ALU_SUB:    y = diff[31:0];
      ALU_AND:    y = a & b;
      ALU_OR:     y = a | b;
      ALU_XOR:    y = a ^ b;
      ALU_SLT:    y = {31'b0, lt_signed};
      ALU_SLTU:   y = {31'b0, diff[32]};
      ALU_PASS_B: y = b;
      default:    y = '0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/rv_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_datapath import rv_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic        clk,
  input  logic        rst,
  input  word_t       idt,
  input  word_t       ddt_in,
  input  imm_src_e    imm_src,
  input  alu_op_e     alu_op,
  input  logic        alu_src,
  input  logic        a_src_pc,
  input  pc_src_e     pc_src,
  input  result_src_e result_src,
  input  logic        reg_write,
  input  fwd_sel_e    fwd_a,
  input  fwd_sel_e    fwd_b,
  input  logic        f_stall,
  input  logic        d_stall,
  input  logic        d_flush,
  input  logic        e_flush,
  output word_t       iad,
  output word_t       dad,
  output word_t       ddt_out,
  output word_t       d_inst,
  output logic        zero,
  output logic        neg,
  output logic        neg_unsigned,
  output reg_idx_t    d_rs1,
  output reg_idx_t    d_rs2,
  output reg_idx_t    e_rs1,
  output reg_idx_t    e_rs2,
  output reg_idx_t    e_rd,
  output reg_idx_t    m_rd,
  output reg_idx_t    w_rd
);

  word_t pc, pc_plus4, pc_target;
  word_t d_pc, d_pc4, d_rd1, d_rd2, d_imm;
  word_t e_pc, e_pc4, e_rd1, e_rd2, e_imm;
  word_t e_fa, e_fb, alu_a, alu_b, e_alu_y;
  word_t m_alu_y, m_wdata, m_pc4;
  word_t w_alu_y, w_rdata, w_pc4, w_result;

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                    word_t wb_val);
    unique case (sel)
      FWD_FROM_MEM: return mem_val;
      FWD_FROM_WB:  return wb_val;
      default:      return reg_val;
    endcase
  endfunction

  // fetch, a redirect from execute wins over a stall
  assign pc_plus4 = pc + 32'd4;
  assign iad      = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (pc_src != PC_PLUS4) begin
      pc <= pc_target;
    end else if (!f_stall) begin
      pc <= pc_plus4;
    end
  end

  // all-zero word decodes as a bubble
  always_ff @(posedge clk) begin
    if (rst || d_flush) begin
      d_inst <= '0;
    end else if (!d_stall) begin
      d_inst <= idt;
    end
  end

  always_ff @(posedge clk) begin
    if (!d_stall) begin
      d_pc  <= pc;
      d_pc4 <= pc_plus4;
    end
  end

  // decode
  assign d_rs1 = d_inst[19:15];
  assign d_rs2 = d_inst[24:20];

  rv_regfile regfile (
    .clk(clk),
    .ra1(d_rs1), .ra2(d_rs2),
    .wa(w_rd), .we(reg_write), .wd(w_result),
    .rd1(d_rd1), .rd2(d_rd2)
  );

  always_comb begin
    unique case (imm_src)
      IMM_S:   d_imm = {{20{d_inst[31]}}, d_inst[31:25], d_inst[11:7]};
      IMM_B:   d_imm = {{19{d_inst[31]}}, d_inst[31], d_inst[7], d_inst[30:25],
                        d_inst[11:8], 1'b0};
      IMM_U:   d_imm = {d_inst[31:12], 12'b0};
      IMM_J:   d_imm = {{11{d_inst[31]}}, d_inst[31], d_inst[19:12], d_inst[20],
                        d_inst[30:21], 1'b0};
      default: d_imm = {{20{d_inst[31]}}, d_inst[31:20]};
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || e_flush) begin
      e_rs1 <= '0;
      e_rs2 <= '0;
      e_rd  <= '0;
    end else begin
      e_rs1 <= d_rs1;
      e_rs2 <= d_rs2;
      e_rd  <= d_inst[11:7];
    end
  end

  always_ff @(posedge clk) begin
    e_pc  <= d_pc;
    e_pc4 <= d_pc4;
    e_rd1 <= d_rd1;
    e_rd2 <= d_rd2;
    e_imm <= d_imm;
  end

  // execute
  assign e_fa  = fwd_mux(fwd_a, e_rd1, m_alu_y, w_result);
  assign e_fb  = fwd_mux(fwd_b, e_rd2, m_alu_y, w_result);
  assign alu_a = a_src_pc ? e_pc : e_fa;
  assign alu_b = alu_src ? e_imm : e_fb;

  rv_alu alu (
    .a(alu_a), .b(alu_b), .op(alu_op), .y(e_alu_y),
    .zero(zero), .neg(neg), .neg_unsigned(neg_unsigned)
  );

  // jalr target is rs1 + imm from the alu with bit 0 cleared
  assign pc_target = (pc_src == PC_JALR) ? {e_alu_y[31:1], 1'b0} : e_pc + e_imm;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_rd <= '0;
      w_rd <= '0;
    end else begin
      m_rd <= e_rd;
      w_rd <= m_rd;
    end
  end

  always_ff @(posedge clk) begin
    m_alu_y <= e_alu_y;
    m_wdata <= e_fb;
    m_pc4   <= e_pc4;
    w_alu_y <= m_alu_y;
    w_rdata <= ddt_in;
    w_pc4   <= m_pc4;
  end

  // memory
  assign dad     = m_alu_y;
  assign ddt_out = m_wdata;

  // writeback
  always_comb begin
    unique case (result_src)
      RES_MEM:      w_result = w_rdata;
      RES_PC_PLUS4: w_result = w_pc4;
      default:      w_result = w_alu_y;
    endcase
  end

endmodule

`default_nettype wire

/* logic/rv_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_controller import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  word_t       d_inst,
  input  logic        zero,
  input  logic        neg,
  input  logic        neg_unsigned,
  input  logic        e_flush,
  output imm_src_e    imm_src,
  output alu_op_e     alu_op,
  output logic        alu_src,
  output logic        a_src_pc,
  output pc_src_e     pc_src,
  output logic        mreq,
  output logic        write,
  output result_src_e e_result_src,
  output result_src_e m_result_src,
  output result_src_e w_result_src,
  output logic        e_reg_write,
  output logic        m_reg_write,
  output logic        w_reg_write
);

  opcode_t     opcode;
  logic [2:0]  funct3;
  logic        d_reg_write, d_mem_req, d_mem_write;
  logic        d_branch, d_jal, d_jalr, d_alu_src, d_a_src_pc;
  alu_op_e     d_alu_op;
  result_src_e d_result_src;
  logic        e_mem_req, e_mem_write, e_branch, e_jal, e_jalr;
  logic [2:0]  e_funct3;
  logic        m_mem_req, m_mem_write;
  logic        taken;

  // shared by register and immediate arithmetic
  function automatic alu_op_e alu_dec(logic [2:0] f3, logic sub);
    unique case (f3)
      3'b000:  return sub ? ALU_SUB : ALU_ADD;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b110:  return ALU_OR;
      3'b111:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  assign opcode = d_inst[6:0];
  assign funct3 = d_inst[14:12];

  // unknown opcodes decode as a bubble
  always_comb begin
    d_reg_write  = 1'b0;
    d_result_src = RES_ALU;
    d_mem_req    = 1'b0;
    d_mem_write  = 1'b0;
    d_branch     = 1'b0;
    d_jal        = 1'b0;
    d_jalr       = 1'b0;
    d_alu_op     = ALU_ADD;
    d_alu_src    = 1'b1;
    d_a_src_pc   = 1'b0;
    imm_src      = IMM_I;
    unique case (opcode)
      OP_R: begin
        d_reg_write = 1'b1;
        d_alu_src   = 1'b0;
        d_alu_op    = alu_dec(funct3, d_inst[30]);
      end
      OP_I: begin
        d_reg_write = 1'b1;
        d_alu_op    = alu_dec(funct3, 1'b0);
      end
      OP_LUI: begin
        d_reg_write = 1'b1;
        d_alu_op    = ALU_PASS_B;
        imm_src     = IMM_U;
      end
      OP_AUIPC: begin
        d_reg_write = 1'b1;
        d_a_src_pc  = 1'b1;
        imm_src     = IMM_U;
      end
      OP_LOAD: begin
        d_reg_write  = 1'b1;
        d_result_src = RES_MEM;
        d_mem_req    = 1'b1;
      end
      OP_STORE: begin
        d_mem_req   = 1'b1;
        d_mem_write = 1'b1;
        imm_src     = IMM_S;
      end
      OP_BRANCH: begin
        d_branch  = 1'b1;
        d_alu_src = 1'b0;
        d_alu_op  = ALU_SUB;
        imm_src   = IMM_B;
      end
      OP_JAL: begin
        d_reg_write  = 1'b1;
        d_result_src = RES_PC_PLUS4;
        d_jal        = 1'b1;
        imm_src      = IMM_J;
      end
      OP_JALR: begin
        d_reg_write  = 1'b1;
        d_result_src = RES_PC_PLUS4;
        d_jalr       = 1'b1;
      end
      default: ;
    endcase
  end

  // decode/execute control that a flush clears to a bubble
  always_ff @(posedge clk) begin
    if (rst || e_flush) begin
      e_reg_write  <= 1'b0;
      e_result_src <= RES_ALU;
      e_mem_req    <= 1'b0;
      e_mem_write  <= 1'b0;
      e_branch     <= 1'b0;
      e_jal        <= 1'b0;
      e_jalr       <= 1'b0;
      e_funct3     <= '0;
      alu_op       <= ALU_ADD;
      alu_src      <= 1'b0;
      a_src_pc     <= 1'b0;
    end else begin
      e_reg_write  <= d_reg_write;
      e_result_src <= d_result_src;
      e_mem_req    <= d_mem_req;
      e_mem_write  <= d_mem_write;
      e_branch     <= d_branch;
      e_jal        <= d_jal;
      e_jalr       <= d_jalr;
      e_funct3     <= funct3;
      alu_op       <= d_alu_op;
      alu_src      <= d_alu_src;
      a_src_pc     <= d_a_src_pc;
    end
  end

  // branch condition from the a - b flags
  always_comb begin
    unique case (e_funct3)
      3'b000:  taken = zero;
      3'b001:  taken = !zero;
      3'b100:  taken = neg;
      3'b101:  taken = !neg;
      3'b110:  taken = neg_unsigned;
      3'b111:  taken = !neg_unsigned;
      default: taken = 1'b0;
    endcase
  end

  assign pc_src = e_jalr ? PC_JALR :
                  (e_jal || (e_branch && taken)) ? PC_BRANCH : PC_PLUS4;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_reg_write  <= 1'b0;
      m_result_src <= RES_ALU;
      m_mem_req    <= 1'b0;
      m_mem_write  <= 1'b0;
      w_reg_write  <= 1'b0;
      w_result_src <= RES_ALU;
    end else begin
      m_reg_write  <= e_reg_write;
      m_result_src <= e_result_src;
      m_mem_req    <= e_mem_req;
      m_mem_write  <= e_mem_write;
      w_reg_write  <= m_reg_write;
      w_result_src <= m_result_src;
    end
  end

  assign mreq  = m_mem_req;
  assign write = m_mem_write;

  // a store strobe always comes with mreq
  a_store_strobe: assert property (@(posedge clk) disable iff (rst) write |-> mreq)
    else $error("write strobe without mreq");

endmodule

`default_nettype wire

/* logic/rv_hazard.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_hazard import rv_pkg::*; (
  input  reg_idx_t    d_rs1,
  input  reg_idx_t    d_rs2,
  input  reg_idx_t    e_rs1,
  input  reg_idx_t    e_rs2,
  input  reg_idx_t    e_rd,
  input  reg_idx_t    m_rd,
  input  reg_idx_t    w_rd,
  input  pc_src_e     pc_src,
  input  result_src_e e_result_src,
  input  result_src_e m_result_src,
  input  logic        e_reg_write,
  input  logic        m_reg_write,
  input  logic        w_reg_write,
  output fwd_sel_e    fwd_a,
  output fwd_sel_e    fwd_b,
  output logic        f_stall,
  output logic        d_stall,
  output logic        d_flush,
  output logic        e_flush
);

  logic lw_stall;
  logic redirect;

  // memory stage wins but only holds alu results ready to forward
  function automatic fwd_sel_e fwd_pick(reg_idx_t rs);
    if (m_reg_write && m_rd != '0 && m_rd == rs && m_result_src == RES_ALU) begin
      return FWD_FROM_MEM;
    end
    if (w_reg_write && w_rd != '0 && w_rd == rs) begin
      return FWD_FROM_WB;
    end
    return FWD_REG;
  endfunction

  always_comb begin
    fwd_a = fwd_pick(e_rs1);
    fwd_b = fwd_pick(e_rs2);
  end

  // load in execute feeding decode
  assign lw_stall = e_reg_write && e_result_src == RES_MEM && e_rd != '0 &&
                    (e_rd == d_rs1 || e_rd == d_rs2);

  assign redirect = (pc_src != PC_PLUS4);

  assign f_stall = lw_stall;
  assign d_stall = lw_stall;
  assign d_flush = redirect;
  assign e_flush = lw_stall || redirect;

  // a load and a branch never sit in execute together
  always_comb begin
    assert (!(d_stall && d_flush)) else $error("decode stalled and flushed together");
  end

endmodule

`default_nettype wire

/* logic/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic  clk,
  input  logic  rst,
  output word_t iad,
  input  word_t idt,
  output word_t dad,
  output logic  mreq,
  output logic  write,
  output word_t ddt_out,
  input  word_t ddt_in
);

  // datapath to controller and hazard unit
  word_t       d_inst;
  logic        e_zero, e_neg, e_neg_unsigned;
  reg_idx_t    d_rs1, d_rs2, e_rs1, e_rs2, e_rd, m_rd, w_rd;

  // controller outputs
  imm_src_e    d_imm_src;
  alu_op_e     e_alu_op;
  logic        e_alu_src, e_a_src_pc;
  pc_src_e     e_pc_src;
  result_src_e e_result_src, m_result_src, w_result_src;
  logic        e_reg_write, m_reg_write, w_reg_write;

  // hazard unit outputs
  fwd_sel_e    e_fwd_a, e_fwd_b;
  logic        f_stall, d_stall, d_flush, e_flush;

  rv_datapath #(
    .RESET_PC(RESET_PC)
  ) datapath (
    .clk(clk), .rst(rst),
    .idt(idt), .ddt_in(ddt_in),
    .imm_src(d_imm_src),
    .alu_op(e_alu_op), .alu_src(e_alu_src), .a_src_pc(e_a_src_pc), .pc_src(e_pc_src),
    .result_src(w_result_src), .reg_write(w_reg_write),
    .fwd_a(e_fwd_a), .fwd_b(e_fwd_b),
    .f_stall(f_stall), .d_stall(d_stall), .d_flush(d_flush), .e_flush(e_flush),
    .iad(iad), .dad(dad), .ddt_out(ddt_out),
    .d_inst(d_inst),
    .zero(e_zero), .neg(e_neg), .neg_unsigned(e_neg_unsigned),
    .d_rs1(d_rs1), .d_rs2(d_rs2), .e_rs1(e_rs1), .e_rs2(e_rs2),
    .e_rd(e_rd), .m_rd(m_rd), .w_rd(w_rd)
  );

  rv_controller controller (
    .clk(clk), .rst(rst),
    .d_inst(d_inst),
    .zero(e_zero), .neg(e_neg), .neg_unsigned(e_neg_unsigned),
    .e_flush(e_flush),
    .imm_src(d_imm_src),
    .alu_op(e_alu_op), .alu_src(e_alu_src), .a_src_pc(e_a_src_pc), .pc_src(e_pc_src),
    .mreq(mreq), .write(write),
    .e_result_src(e_result_src), .m_result_src(m_result_src), .w_result_src(w_result_src),
    .e_reg_write(e_reg_write), .m_reg_write(m_reg_write), .w_reg_write(w_reg_write)
  );

  rv_hazard hazard (
    .d_rs1(d_rs1), .d_rs2(d_rs2), .e_rs1(e_rs1), .e_rs2(e_rs2),
    .e_rd(e_rd), .m_rd(m_rd), .w_rd(w_rd),
    .pc_src(e_pc_src),
    .e_result_src(e_result_src), .m_result_src(m_result_src),
    .e_reg_write(e_reg_write), .m_reg_write(m_reg_write), .w_reg_write(w_reg_write),
    .fwd_a(e_fwd_a), .fwd_b(e_fwd_b),
    .f_stall(f_stall), .d_stall(d_stall), .d_flush(d_flush), .e_flush(e_flush)
  );

endmodule

`default_nettype wire

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

  localparam int    NROWS       = 7;
  localparam int    MAX_INSTS   = 16;
  localparam int    CYCLE_LIMIT = 200 * NROWS;
  // only flushed instructions store here
  localparam word_t FLUSH_ADDR  = 32'h0000_00fc;

  // funct3 and funct7 values from the RV32I encoding
  localparam int F_ADD  = 0;
  localparam int F_SLT  = 2;
  localparam int F_SLTU = 3;
  localparam int F_XOR  = 4;
  localparam int F_OR   = 6;
  localparam int F_AND  = 7;
  localparam int F_BEQ  = 0;
  localparam int F_BNE  = 1;
  localparam int F_BLT  = 4;
  localparam int F_BGE  = 5;
  localparam int F7_SUB = 32;

  logic  clk;
  logic  rst;
  word_t iad, idt, dad, ddt_out, ddt_in;
  logic  mreq, write;

  word_t imem [64];
  word_t dmem [64];
  word_t log_addr [$];
  word_t log_data [$];

  // program table
  string row_name [NROWS];
  word_t prog     [NROWS][MAX_INSTS];
  int    row_len  [NROWS];
  word_t exp_addr [NROWS];
  word_t exp_data [NROWS];

  int n_rows  = 0;
  int cur_row = 0;
  int errors  = 0;
  int cycles  = 0;

  rv_core #(
    .RESET_PC(32'h0)
  ) dut (
    .clk(clk), .rst(rst),
    .iad(iad), .idt(idt),
    .dad(dad), .mreq(mreq), .write(write),
    .ddt_out(ddt_out), .ddt_in(ddt_in)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // both memories answer in the same cycle
  assign idt    = imem[iad[7:2]];
  assign ddt_in = dmem[dad[7:2]];

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 64; i++) begin
        dmem[i] <= '0;
      end
      log_addr.delete();
      log_data.delete();
    end else if (mreq && write) begin
      dmem[dad[7:2]] <= ddt_out;
      log_addr.push_back(dad);
      log_data.push_back(ddt_out);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: row %s never reached its end marker within %0d cycles",
               row_name[cur_row], CYCLE_LIMIT);
      $display("errors: %0d", errors + 1);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // instruction encoders
  function automatic word_t r_type(input int f3, input int f7, input int rd,
                                   input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t i_type(input int f3, input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
  endfunction

  function automatic word_t lw_inst(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic word_t sw_inst(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(input int f3, input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic word_t jal_inst(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic word_t jalr_inst(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
  endfunction

  function automatic word_t lui_inst(input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic word_t auipc_inst(input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], 7'b0010111};
  endfunction

  task automatic start_row(input string name, input word_t addr, input word_t data);
    row_name[n_rows] = name;
    exp_addr[n_rows] = addr;
    exp_data[n_rows] = data;
    row_len[n_rows]  = 0;
  endtask

  task automatic emit(input word_t inst);
    prog[n_rows][row_len[n_rows]] = inst;
    row_len[n_rows]++;
  endtask

  // every program ends in a jump to itself
  task automatic close_row();
    emit(jal_inst(0, 0));
    n_rows++;
  endtask

  task automatic build_table();
    // -5 and 3 through slt, sltu and slti folded into one weighted sum
    start_row("slt_compare", 32'h10, 32'hf);
    emit(i_type(F_ADD, 1, 0, -5));
    emit(i_type(F_ADD, 2, 0, 3));
    emit(r_type(F_SLT, 0, 3, 1, 2));
    emit(r_type(F_SLTU, 0, 4, 1, 2));
    emit(r_type(F_SLTU, 0, 5, 2, 1));
    emit(i_type(F_SLT, 6, 1, -4));
    emit(r_type(F_SLT, 0, 7, 2, 1));
    emit(r_type(F_ADD, 0, 8, 3, 5));
    emit(r_type(F_ADD, 0, 8, 8, 8));
    emit(r_type(F_ADD, 0, 8, 8, 6));
    emit(r_type(F_ADD, 0, 8, 8, 8));
    emit(r_type(F_ADD, 0, 8, 8, 4));
    emit(r_type(F_ADD, 0, 8, 8, 7));
    emit(r_type(F_ADD, F7_SUB, 8, 8, 1));
    emit(sw_inst(8, 0, 16));
    close_row();

    start_row("logic_ops", 32'h20, 32'hffff_fe77);
    emit(lui_inst(1, 'h12345));
    emit(i_type(F_OR, 1, 1, 'h678));
    emit(i_type(F_ADD, 2, 0, 'hf0));
    emit(r_type(F_AND, 0, 3, 1, 2));
    emit(r_type(F_OR, 0, 4, 1, 2));
    emit(r_type(F_XOR, 0, 5, 1, 2));
    emit(i_type(F_AND, 6, 1, -256));
    emit(i_type(F_XOR, 7, 1, -1));
    emit(r_type(F_ADD, 0, 8, 3, 4));
    emit(r_type(F_ADD, 0, 8, 8, 5));
    emit(r_type(F_ADD, F7_SUB, 8, 8, 6));
    emit(r_type(F_XOR, 0, 8, 8, 7));
    emit(sw_inst(8, 0, 32));
    close_row();

    // each result feeds the next one directly
    start_row("fwd_chain", 32'h44, 32'h3e);
    emit(i_type(F_ADD, 6, 0, 64));
    emit(i_type(F_ADD, 1, 0, 7));
    emit(i_type(F_ADD, 2, 1, 5));
    emit(r_type(F_ADD, 0, 3, 1, 2));
    emit(r_type(F_ADD, F7_SUB, 4, 3, 1));
    emit(r_type(F_ADD, 0, 5, 4, 3));
    emit(r_type(F_ADD, 0, 5, 5, 5));
    emit(sw_inst(5, 6, 4));
    close_row();

    start_row("load_use", 32'h38, 32'hc9);
    emit(i_type(F_ADD, 1, 0, 100));
    emit(i_type(F_ADD, 2, 0, 48));
    emit(sw_inst(1, 2, 0));
    emit(lw_inst(3, 2, 0));
    emit(i_type(F_ADD, 4, 3, 1));
    emit(lw_inst(5, 2, 0));
    emit(r_type(F_ADD, 0, 6, 5, 4));
    emit(sw_inst(6, 2, 4));
    emit(lw_inst(7, 2, 4));
    emit(sw_inst(7, 2, 8));
    close_row();

    // x1 = -3 and x2 = 4 while skipped slots add large weights or store to FLUSH_ADDR
    start_row("branches", 32'h0c, 32'h3);
    emit(i_type(F_ADD, 1, 0, -3));
    emit(i_type(F_ADD, 2, 0, 4));
    emit(b_type(F_BEQ, 1, 2, 8));
    emit(i_type(F_ADD, 10, 0, 1));
    emit(b_type(F_BNE, 1, 2, 8));
    emit(sw_inst(0, 0, 252));
    emit(b_type(F_BLT, 1, 2, 12));
    emit(i_type(F_ADD, 10, 10, 64));
    emit(sw_inst(0, 0, 252));
    emit(b_type(F_BGE, 1, 2, 8));
    emit(i_type(F_ADD, 10, 10, 2));
    emit(b_type(F_BGE, 2, 1, 8));
    emit(i_type(F_ADD, 10, 10, 128));
    emit(b_type(F_BLT, 2, 1, 8));
    emit(sw_inst(10, 0, 12));
    close_row();

    // links are 4 and 20 and the jalr target 33 lands on 32
    start_row("jal_jalr", 32'h50, 32'h18);
    emit(jal_inst(1, 12));
    emit(sw_inst(0, 0, 252));
    emit(i_type(F_ADD, 1, 0, 0));
    emit(i_type(F_ADD, 2, 0, 28));
    emit(jalr_inst(3, 2, 5));
    emit(sw_inst(0, 0, 252));
    emit(i_type(F_ADD, 1, 0, 0));
    emit(sw_inst(0, 0, 252));
    emit(r_type(F_ADD, 0, 4, 1, 3));
    emit(i_type(F_ADD, 6, 0, 80));
    emit(sw_inst(4, 6, 0));
    close_row();

    start_row("lui_auipc", 32'h68, 32'habcd_effc);
    emit(lui_inst(1, 'habcde));
    emit(auipc_inst(2, 1));
    emit(auipc_inst(3, 0));
    emit(i_type(F_ADD, 4, 3, 100));
    emit(r_type(F_ADD, 0, 5, 1, 2));
    emit(r_type(F_ADD, F7_SUB, 5, 5, 3));
    emit(sw_inst(5, 4, -4));
    close_row();
  endtask

  task automatic check_addr(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: address expected 0x%08h, actual 0x%08h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_data(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: data expected 0x%08h, actual 0x%08h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic run_row(input int r);
    word_t marker;
    int    hits;

    cur_row = r;
    marker  = (row_len[r] - 1) * 4;
    hits    = 0;
    @(posedge clk);
    #1 rst = 1'b1;
    for (int i = 0; i < 64; i++) begin
      imem[i] = (i < row_len[r]) ? prog[r][i] : '0;
    end
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    check_addr({row_name[r], " first fetch"}, 32'h0, iad);
    if (mreq || write) begin
      $display("row %s: data strobe active right after reset", row_name[r]);
      errors++;
    end
    // the self-jump refetches its own address once per loop
    while (hits < 4) begin
      @(posedge clk);
      #1;
      if (iad == marker) begin
        hits++;
      end
    end
    foreach (log_addr[i]) begin
      if (log_addr[i] == FLUSH_ADDR) begin
        $display("row %s: a flushed store reached the data port", row_name[r]);
        errors++;
      end
    end
    if (log_addr.size() == 0) begin
      $display("row %s: program ended without any store", row_name[r]);
      errors++;
    end else begin
      check_addr(row_name[r], exp_addr[r], log_addr[$]);
      check_data(row_name[r], exp_data[r], log_data[$]);
    end
  endtask

  initial begin
    rst = 1'b1;
    build_table();
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_datapath.sv
logic/rv_controller.sv
logic/rv_hazard.sv
logic/rv_core.sv
bench/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f flist.f --top-module rv_core_tb -o rv_core_sim

out=$(./obj_dir/rv_core_sim)
echo "$out"

if echo "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
